// ==== design/cpu_cfg_pkg.sv ====
// CPU configuration package with word width, register file size, memory depths and reset PC
package cpu_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath and register file
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned data_w     = 32;                 // Data word width
    localparam int unsigned reg_count  = 16;                 // Architectural registers
    localparam int unsigned reg_addr_w = $clog2(reg_count);  // Register index width

    ////////////////////////////////////////////////////////////////////////////
    // Word-addressed memories
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned imem_depth  = 64;                 // Instruction words
    localparam int unsigned dmem_depth  = 64;                 // Data words
    localparam int unsigned imem_addr_w = $clog2(imem_depth); // Also the PC width
    localparam int unsigned dmem_addr_w = $clog2(dmem_depth); // Data address width

    // First fetch address after reset
    localparam logic [imem_addr_w-1:0] reset_pc = '0;

endpackage : cpu_cfg_pkg

// ==== design/isa_pkg.sv ====
// Instruction set package with opcodes, instruction field positions and ALU operation codes
package isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Field layout of one instruction word
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned op_w    = 5;   // Opcode width
    localparam int unsigned aluop_w = 4;   // ALU operation width
    localparam int unsigned imm_w   = 15;  // Immediate width before extension
    localparam int unsigned ctrl_w  = 11;  // Decoder control word width

    localparam int unsigned op_msb  = 31;
    localparam int unsigned op_lsb  = 27;
    localparam int unsigned rd_msb  = 26;  // Destination when reg_dst set
    localparam int unsigned rd_lsb  = 23;
    localparam int unsigned rs_msb  = 22;  // First source
    localparam int unsigned rs_lsb  = 19;
    localparam int unsigned rt_msb  = 18;  // Second source or destination
    localparam int unsigned rt_lsb  = 15;
    localparam int unsigned imm_msb = 14;  // Sign bit of immediate
    localparam int unsigned imm_lsb = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [op_w-1:0] op_noop = 5'b00000;
    localparam logic [op_w-1:0] op_jr   = 5'b00001;  // PC from rs
    localparam logic [op_w-1:0] op_bne  = 5'b00010;
    localparam logic [op_w-1:0] op_be   = 5'b00011;
    localparam logic [op_w-1:0] op_bl   = 5'b00100;
    localparam logic [op_w-1:0] op_bg   = 5'b00101;
    localparam logic [op_w-1:0] op_ble  = 5'b00110;
    localparam logic [op_w-1:0] op_bge  = 5'b00111;
    localparam logic [op_w-1:0] op_lilo = 5'b01010;  // Load immediate
    localparam logic [op_w-1:0] op_lw   = 5'b01110;
    localparam logic [op_w-1:0] op_sw   = 5'b01111;
    localparam logic [op_w-1:0] op_rst  = 5'b10010;  // Clear rt
    localparam logic [op_w-1:0] op_add  = 5'b10011;
    localparam logic [op_w-1:0] op_xor  = 5'b10110;
    localparam logic [op_w-1:0] op_and  = 5'b10111;
    localparam logic [op_w-1:0] op_or   = 5'b11000;
    localparam logic [op_w-1:0] op_mult = 5'b11010;  // Low word into rt
    localparam logic [op_w-1:0] op_sll  = 5'b11110;
    localparam logic [op_w-1:0] op_slr  = 5'b11111;

    ////////////////////////////////////////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [aluop_w-1:0] alu_add   = 4'b0000;
    localparam logic [aluop_w-1:0] alu_and   = 4'b0001;
    localparam logic [aluop_w-1:0] alu_or    = 4'b0010;
    localparam logic [aluop_w-1:0] alu_xor   = 4'b0011;
    localparam logic [aluop_w-1:0] alu_mul   = 4'b0100;
    localparam logic [aluop_w-1:0] alu_sll   = 4'b0101;
    localparam logic [aluop_w-1:0] alu_srl   = 4'b0110;
    localparam logic [aluop_w-1:0] alu_zero  = 4'b0111;
    localparam logic [aluop_w-1:0] alu_be    = 4'b1000;  // Branch compares
    localparam logic [aluop_w-1:0] alu_bne   = 4'b1001;
    localparam logic [aluop_w-1:0] alu_bl    = 4'b1010;
    localparam logic [aluop_w-1:0] alu_bg    = 4'b1011;
    localparam logic [aluop_w-1:0] alu_ble   = 4'b1100;
    localparam logic [aluop_w-1:0] alu_bge   = 4'b1101;
    localparam logic [aluop_w-1:0] alu_passb = 4'b1111;  // Immediate through

endpackage : isa_pkg

// ==== design/maindec.sv ====
// Main decoder turning the 5-bit opcode into the datapath control signals
`timescale 1ns/100ps

module maindec import isa_pkg::*; (
    input  logic [op_w-1:0]    op,
    output logic               reg_write,
    output logic               reg_dst,
    output logic               branch,
    output logic               mem_write,
    output logic               mem_to_reg,
    output logic               jump,
    output logic               alu_src,
    output logic [aluop_w-1:0] aluop
);

    logic [ctrl_w-1:0] controls;  // Packed control word

    // Flag bits first, then aluop, with alu_src as the lowest bit
    assign {reg_write, reg_dst, branch, mem_write,
            mem_to_reg, jump, aluop, alu_src} = controls;

    ////////////////////////////////////////////////////////////////////////////
    // Control table
    ////////////////////////////////////////////////////////////////////////////

    // Leading six bits are reg_write, reg_dst, branch, mem_write, mem_to_reg, jump
    always_comb begin
        case (op)
            op_noop: controls = {6'b000000, alu_add,   1'b0};
            op_jr:   controls = {6'b000001, alu_add,   1'b0};  // Target from rs
            op_bne:  controls = {6'b001000, alu_bne,   1'b0};
            op_be:   controls = {6'b001000, alu_be,    1'b0};
            op_bl:   controls = {6'b001000, alu_bl,    1'b0};
            op_bg:   controls = {6'b001000, alu_bg,    1'b0};
            op_ble:  controls = {6'b001000, alu_ble,   1'b0};
            op_bge:  controls = {6'b001000, alu_bge,   1'b0};
            op_lilo: controls = {6'b110000, alu_passb, 1'b1};  // Imm into rd
            op_lw:   controls = {6'b100010, alu_add,   1'b1};  // rs+imm address
            op_sw:   controls = {6'b000100, alu_add,   1'b1};
            op_rst:  controls = {6'b100000, alu_zero,  1'b0};  // Zero into rt
            op_add:  controls = {6'b110000, alu_add,   1'b0};
            op_xor:  controls = {6'b110000, alu_xor,   1'b0};
            op_and:  controls = {6'b110000, alu_and,   1'b0};
            op_or:   controls = {6'b110000, alu_or,    1'b0};
            op_mult: controls = {6'b100000, alu_mul,   1'b0};  // Writes rt
            op_sll:  controls = {6'b110000, alu_sll,   1'b0};
            op_slr:  controls = {6'b110000, alu_srl,   1'b0};
            // Anything unlisted runs as NOOP
            default: controls = '0;
        endcase
    end

endmodule : maindec

// ==== design/alu.sv ====
// ALU with arithmetic, logic, shift, multiply and signed branch compare
`timescale 1ns/100ps

module alu import cpu_cfg_pkg::*, isa_pkg::*; (
    input  logic [data_w-1:0]  a,       // rs
    input  logic [data_w-1:0]  b,       // rt or extended immediate
    input  logic [aluop_w-1:0] aluop,
    output logic [data_w-1:0]  result,
    output logic               cond     // Branch condition met
);

    logic [4:0]        shamt;   // Shift distance
    logic [data_w-1:0] sum;
    logic              eq;
    logic              lt;      // Signed a < b

    assign shamt = b[4:0];
    assign sum   = a + b;
    assign eq    = (a == b);
    assign lt    = ($signed(a) < $signed(b));

    ////////////////////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (aluop)
            alu_add:   result = sum;
            alu_and:   result = a & b;
            alu_or:    result = a | b;
            alu_xor:   result = a ^ b;
            alu_mul:   result = a * b;       // Low word kept
            alu_sll:   result = a << shamt;
            alu_srl:   result = a >> shamt;  // Logical shift with zero fill
            alu_zero:  result = '0;
            alu_passb: result = b;
            default:   result = sum;         // Branch codes fall here
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Branch condition
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (aluop)
            alu_be:  cond = eq;
            alu_bne: cond = ~eq;
            alu_bl:  cond = lt;
            alu_bg:  cond = ~lt & ~eq;
            alu_ble: cond = lt | eq;
            alu_bge: cond = ~lt;
            default: cond = 1'b0;  // Not a branch
        endcase
    end

endmodule : alu

// ==== design/regfile.sv ====
// Register file with two combinational reads, one clocked write and register 0 tied to zero
`timescale 1ns/100ps

module regfile import cpu_cfg_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] ra1,
    input  logic [reg_addr_w-1:0] ra2,
    input  logic [reg_addr_w-1:0] wa,
    input  logic [data_w-1:0]     wd,
    output logic [data_w-1:0]     rd1,
    output logic [data_w-1:0]     rd2
);

    logic [data_w-1:0] regs [reg_count];

    // Reset wipes every entry
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;                       // Visible next cycle
        end
    end

    // Index 0 always reads back as zero
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule : regfile

// ==== design/datapath.sv ====
// Datapath with PC, next-PC select, immediate extension, register file, ALU and write-back
`timescale 1ns/100ps

module datapath import cpu_cfg_pkg::*, isa_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   reg_write,
    input  logic                   reg_dst,
    input  logic                   branch,
    input  logic                   mem_write,
    input  logic                   mem_to_reg,
    input  logic                   jump,
    input  logic                   alu_src,
    input  logic [aluop_w-1:0]     aluop,
    input  logic [data_w-1:0]      instr,
    input  logic [data_w-1:0]      read_data,      // From data memory
    output logic [op_w-1:0]        op,             // To decoder
    output logic [imem_addr_w-1:0] pc,
    output logic                   mem_write_out,
    output logic [data_w-1:0]      alu_out,        // Also the data address
    output logic [data_w-1:0]      write_data      // Store data
);

    logic [reg_addr_w-1:0]  rs;
    logic [reg_addr_w-1:0]  rt;
    logic [reg_addr_w-1:0]  rd;
    logic [reg_addr_w-1:0]  write_reg;
    logic [data_w-1:0]      imm_ext;
    logic [data_w-1:0]      rd1;
    logic [data_w-1:0]      rd2;
    logic [data_w-1:0]      src_b;
    logic [data_w-1:0]      result;
    logic                   cond;
    logic [imem_addr_w-1:0] pc_plus1;
    logic [imem_addr_w-1:0] pc_branch;
    logic [imem_addr_w-1:0] pc_next;

    ////////////////////////////////////////////////////////////////////////////
    // Field split and immediate
    ////////////////////////////////////////////////////////////////////////////

    assign op = instr[op_msb:op_lsb];
    assign rd = instr[rd_msb:rd_lsb];
    assign rs = instr[rs_msb:rs_lsb];
    assign rt = instr[rt_msb:rt_lsb];

    // Sign extend 15-bit immediate
    assign imm_ext = {{(data_w-imm_w){instr[imm_msb]}}, instr[imm_msb:imm_lsb]};

    ////////////////////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////////////////////

    assign pc_plus1  = pc + 1'b1;
    assign pc_branch = pc_plus1 + imm_ext[imem_addr_w-1:0];  // Wraps in imem

    always_comb begin
        if (jump) begin
            pc_next = rd1[imem_addr_w-1:0];  // JR target
        end else if (branch && cond) begin
            pc_next = pc_branch;
        end else begin
            pc_next = pc_plus1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register file, ALU and write-back
    ////////////////////////////////////////////////////////////////////////////

    assign write_reg = reg_dst ? rd : rt;               // rd for R-type and LILO
    assign src_b     = alu_src ? imm_ext : rd2;

    regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .we    (reg_write),
        .ra1   (rs),
        .ra2   (rt),
        .wa    (write_reg),
        .wd    (result),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    alu u_alu (
        .a      (rd1),
        .b      (src_b),
        .aluop  (aluop),
        .result (alu_out),
        .cond   (cond)
    );

    assign result        = mem_to_reg ? read_data : alu_out;  // LW takes memory
    assign write_data    = rd2;                               // SW stores rt
    assign mem_write_out = mem_write & ~reset;                // No stores in reset

endmodule : datapath

// ==== design/imem.sv ====
// Instruction memory with a clocked load port and combinational fetch
`timescale 1ns/100ps

module imem import cpu_cfg_pkg::*; (
    input  logic                   clk,
    input  logic                   prog_we,    // Loader strobe
    input  logic [imem_addr_w-1:0] prog_addr,
    input  logic [data_w-1:0]      prog_data,
    input  logic [imem_addr_w-1:0] addr,       // PC
    output logic [data_w-1:0]      instr
);

    logic [data_w-1:0] mem [imem_depth];

    ////////////////////////////////////////////////////////////////////////////
    // Program load
    ////////////////////////////////////////////////////////////////////////////

    // Written while the core sits in reset
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////////////////////

    assign instr = mem[addr];  // Same-cycle read

endmodule : imem

// ==== design/dmem.sv ====
// Data memory with combinational read and clocked write
`timescale 1ns/100ps

module dmem import cpu_cfg_pkg::*; (
    input  logic                   clk,
    input  logic                   we,     // SW strobe
    input  logic [dmem_addr_w-1:0] addr,   // Word address
    input  logic [data_w-1:0]      wd,
    output logic [data_w-1:0]      rd
);

    logic [data_w-1:0] mem [dmem_depth];

    ////////////////////////////////////////////////////////////////////////////
    // Store
    ////////////////////////////////////////////////////////////////////////////

    // Lands at the closing edge of the SW cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wd;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Load
    ////////////////////////////////////////////////////////////////////////////

    assign rd = mem[addr];  // LW result same cycle

endmodule : dmem

// ==== design/cpu_top.sv ====
// Single-cycle CPU top tying decoder, datapath and both memories together
`timescale 1ns/100ps

module cpu_top import cpu_cfg_pkg::*, isa_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   prog_we,     // Program load port
    input  logic [imem_addr_w-1:0] prog_addr,
    input  logic [data_w-1:0]      prog_data,
    output logic [imem_addr_w-1:0] pc,
    output logic                   mem_write,   // Store port
    output logic [dmem_addr_w-1:0] mem_addr,
    output logic [data_w-1:0]      mem_wdata
);

    logic [op_w-1:0]    op;
    logic               reg_write;
    logic               reg_dst;
    logic               branch;
    logic               dec_mem_write;  // Before reset gating
    logic               mem_to_reg;
    logic               jump;
    logic               alu_src;
    logic [aluop_w-1:0] aluop;
    logic [data_w-1:0]  instr;
    logic [data_w-1:0]  read_data;
    logic [data_w-1:0]  alu_out;

    maindec u_maindec (
        .op         (op),
        .reg_write  (reg_write),
        .reg_dst    (reg_dst),
        .branch     (branch),
        .mem_write  (dec_mem_write),
        .mem_to_reg (mem_to_reg),
        .jump       (jump),
        .alu_src    (alu_src),
        .aluop      (aluop)
    );

    datapath u_datapath (
        .clk           (clk),
        .reset         (reset),
        .reg_write     (reg_write),
        .reg_dst       (reg_dst),
        .branch        (branch),
        .mem_write     (dec_mem_write),
        .mem_to_reg    (mem_to_reg),
        .jump          (jump),
        .alu_src       (alu_src),
        .aluop         (aluop),
        .instr         (instr),
        .read_data     (read_data),
        .op            (op),
        .pc            (pc),
        .mem_write_out (mem_write),
        .alu_out       (alu_out),
        .write_data    (mem_wdata)
    );

    assign mem_addr = alu_out[dmem_addr_w-1:0];  // Low bits of rs+imm

    imem u_imem (
        .clk       (clk),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .addr      (pc),
        .instr     (instr)
    );

    dmem u_dmem (
        .clk  (clk),
        .we   (mem_write),
        .addr (mem_addr),
        .wd   (mem_wdata),
        .rd   (read_data)
    );

endmodule : cpu_top

// ==== test/tb_program.svh ====
// CPU test program with the hand-derived list of stores it must produce
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int prog_len    = 48;
localparam int store_count = 13;
localparam logic [imem_addr_w-1:0] done_pc = 47;  // Final JR to itself

logic [data_w-1:0]      prog_words [prog_len];
logic [dmem_addr_w-1:0] exp_addr   [store_count];
logic [data_w-1:0]      exp_data   [store_count];

// Packs the op, rd, rs, rt and imm fields into one word
function automatic logic [data_w-1:0] encode(logic [op_w-1:0] op, int rd, int rs, int rt,
                                             int imm);
    encode = {op, rd[reg_addr_w-1:0], rs[reg_addr_w-1:0], rt[reg_addr_w-1:0], imm[imm_w-1:0]};
endfunction

////////////////////////////////////////////////////////////////////////////
// Program with r1 = 7 and r2 = -3 from word 2 on
////////////////////////////////////////////////////////////////////////////

task automatic fill_program();
    prog_words[0]  = encode(op_sw,   0, 0, 5, 1);     // r5 still clear so stores 0
    prog_words[1]  = encode(op_lilo, 1, 0, 0, 7);
    prog_words[2]  = encode(op_lilo, 2, 0, 0, -3);
    prog_words[3]  = encode(op_add,  3, 1, 2, 0);     // r3 = 4
    prog_words[4]  = encode(op_sw,   0, 0, 3, 2);
    prog_words[5]  = encode(op_and,  4, 1, 2, 0);     // r4 = 5
    prog_words[6]  = encode(op_sw,   0, 0, 4, 3);
    prog_words[7]  = encode(op_or,   5, 1, 2, 0);     // All ones
    prog_words[8]  = encode(op_sw,   0, 0, 5, 4);
    prog_words[9]  = encode(op_xor,  6, 1, 2, 0);     // 0xfffffffa
    prog_words[10] = encode(op_sw,   0, 0, 6, 5);
    prog_words[11] = encode(op_mult, 0, 1, 3, 0);     // r3 = 7 * 4 into rt
    prog_words[12] = encode(op_sw,   0, 0, 3, 6);
    prog_words[13] = encode(op_sll,  7, 1, 3, 0);     // 7 << 28
    prog_words[14] = encode(op_sw,   0, 0, 7, 7);
    prog_words[15] = encode(op_slr,  8, 2, 4, 0);     // Logical shift by 5
    prog_words[16] = encode(op_sw,   0, 0, 8, 8);
    prog_words[17] = encode(op_rst,  0, 0, 8, 0);     // Clears rt
    prog_words[18] = encode(op_sw,   0, 0, 8, 9);
    prog_words[19] = encode(op_lw,   0, 4, 9, 2);     // mem[5 + 2]
    prog_words[20] = encode(op_sw,   0, 3, 9, -1);    // 28 - 1
    // Each compare first falls through onto a bad store and then jumps it
    prog_words[21] = encode(op_be,   0, 1, 2, 1);
    prog_words[22] = encode(op_be,   0, 1, 1, 1);
    prog_words[23] = encode(op_sw,   0, 0, 6, 63);
    prog_words[24] = encode(op_bne,  0, 1, 1, 1);
    prog_words[25] = encode(op_bne,  0, 1, 2, 1);
    prog_words[26] = encode(op_sw,   0, 0, 6, 63);
    prog_words[27] = encode(op_bl,   0, 1, 2, 1);     // Unsigned would take it
    prog_words[28] = encode(op_bl,   0, 2, 1, 1);
    prog_words[29] = encode(op_sw,   0, 0, 6, 63);
    prog_words[30] = encode(op_bg,   0, 2, 1, 1);
    prog_words[31] = encode(op_bg,   0, 1, 2, 1);
    prog_words[32] = encode(op_sw,   0, 0, 6, 63);
    prog_words[33] = encode(op_ble,  0, 1, 2, 1);
    prog_words[34] = encode(op_ble,  0, 1, 1, 1);     // Equal case
    prog_words[35] = encode(op_sw,   0, 0, 6, 63);
    prog_words[36] = encode(op_bge,  0, 2, 1, 1);
    prog_words[37] = encode(op_bge,  0, 1, 1, 1);
    prog_words[38] = encode(op_sw,   0, 0, 6, 63);
    prog_words[39] = encode(op_lilo, 10, 0, 0, 42);
    prog_words[40] = encode(op_jr,   0, 10, 0, 0);
    prog_words[41] = encode(op_sw,   0, 0, 6, 63);    // Jumped over
    prog_words[42] = encode(op_sw,   0, 0, 10, 10);   // JR landing
    prog_words[43] = encode(op_sw,   0, 0, 1, 11);
    prog_words[44] = encode(5'b01000, 1, 2, 1, 'h55); // Unlisted opcode
    prog_words[45] = encode(op_sw,   0, 0, 1, 12);
    prog_words[46] = encode(op_lilo, 12, 0, 0, 47);
    prog_words[47] = encode(op_jr,   0, 12, 0, 0);    // Parks here
endtask

////////////////////////////////////////////////////////////////////////////
// Expected stores in order by address and data
////////////////////////////////////////////////////////////////////////////

task automatic set_expected_store(int idx, int addr, logic [data_w-1:0] data);
    exp_addr[idx] = dmem_addr_w'(addr);
    exp_data[idx] = data;
endtask

task automatic fill_expected();
    set_expected_store(0,  1,  32'h0000_0000);
    set_expected_store(1,  2,  32'h0000_0004);
    set_expected_store(2,  3,  32'h0000_0005);
    set_expected_store(3,  4,  32'hffff_ffff);
    set_expected_store(4,  5,  32'hffff_fffa);
    set_expected_store(5,  6,  32'h0000_001c);
    set_expected_store(6,  7,  32'h7000_0000);
    set_expected_store(7,  8,  32'h07ff_ffff);
    set_expected_store(8,  9,  32'h0000_0000);
    set_expected_store(9,  27, 32'h7000_0000);  // Loaded back from 7
    set_expected_store(10, 10, 32'h0000_002a);  // r10 holds the target
    set_expected_store(11, 11, 32'h0000_0007);
    set_expected_store(12, 12, 32'h0000_0007);  // r1 kept over bad opcode
endtask

`endif

// ==== test/tb_cpu.sv ====
// Testbench for the single-cycle CPU that loads a program and checks every store
`timescale 1ns/100ps

module tb_cpu
    import cpu_cfg_pkg::*, isa_pkg::*;
();

    localparam int clk_half   = 10;
    localparam int reset_tail = 16;  // Reset cycles after the load

    logic                   clk;
    logic                   reset;
    logic                   prog_we;
    logic [imem_addr_w-1:0] prog_addr;
    logic [data_w-1:0]      prog_data;
    logic [imem_addr_w-1:0] pc;
    logic                   mem_write;
    logic [dmem_addr_w-1:0] mem_addr;
    logic [data_w-1:0]      mem_wdata;

    int   store_idx   = 0;     // Next expected store
    logic reset_armed = 1'b0;  // PC settled after first edge

    `include "tb_program.svh"

    localparam int watchdog_cycles = 5 * prog_len + 1 + reset_tail;

    cpu_top uut (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc        (pc),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    initial clk = 1'b0;
    always #(clk_half) clk = ~clk;

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
        $display("FAIL %s: got %h, expected %h", name, got, want);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Store and reset checks
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        reset_armed <= 1'b1;
        if (mem_write) begin
            store_idx <= store_idx + 1;
        end
    end

    no_store_in_reset: assert property (@(posedge clk) reset |-> !mem_write)
        else report_mismatch("mem_write", 32'($sampled(mem_write)), 32'h0);

    pc_held_in_reset: assert property (@(posedge clk) (reset && reset_armed) |-> pc == reset_pc)
        else report_mismatch("pc", 32'($sampled(pc)), 32'(reset_pc));

    store_in_list: assert property (@(posedge clk) mem_write |-> store_idx < store_count)
        else begin
            $display("Store to address %h came after the last expected store",
                     $sampled(mem_addr));
            $display("TESTBENCH FAILED");
            $fatal(1);
        end

    store_addr_ok: assert property (@(posedge clk)
            (mem_write && store_idx < store_count) |-> mem_addr == exp_addr[store_idx])
        else report_mismatch("mem_addr", 32'($sampled(mem_addr)),
                             32'(exp_addr[$sampled(store_idx)]));

    store_data_ok: assert property (@(posedge clk)
            (mem_write && store_idx < store_count) |-> mem_wdata == exp_data[store_idx])
        else report_mismatch("mem_wdata", $sampled(mem_wdata), exp_data[$sampled(store_idx)]);

    ////////////////////////////////////////////////////////////////////////////
    // Load, run and verdict
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        fill_program();
        fill_expected();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;                 // One word per cycle
            prog_addr <= imem_addr_w'(i);
            prog_data <= prog_words[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (reset_tail) @(posedge clk);   // Reset still high
        reset <= 1'b0;
        do begin
            @(negedge clk);                    // Outputs settled
        end while (pc !== done_pc);
        if (store_idx != store_count) begin
            $display("Only %0d of %0d expected stores seen before the final JR",
                     store_idx, store_count);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

    // Load, reset tail and four cycles per program word
    initial begin
        #(watchdog_cycles * 2 * clk_half);
        $display("Timeout, the program never reached its final JR");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule : tb_cpu

// ==== src.f ====
+incdir+test
design/cpu_cfg_pkg.sv
design/isa_pkg.sv
design/maindec.sv
design/alu.sv
design/regfile.sv
design/datapath.sv
design/imem.sv
design/dmem.sv
design/cpu_top.sv
test/tb_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the CPU testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu -f src.f -o sim_cpu

# A failing run exits nonzero, the log decides below
./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi
exit 0
